// File: logic/exec_pkg.sv
package exec_pkg;

  // General-register value or memory address
  typedef logic [63:0] word_t;

  // Destination entry in the reorder buffer
  typedef logic [4:0] rob_idx_t;

  typedef enum logic [3:0] {
    FU_OP_PLUS,
    FU_OP_MINUS,
    FU_OP_ORN,
    FU_OP_OR,
    FU_OP_EOR,
    FU_OP_AND,
    FU_OP_CSNEG,
    FU_OP_CSINC,
    FU_OP_CSINV,
    FU_OP_CSEL,
    FU_OP_MOV,
    FU_OP_LDUR,
    FU_OP_STUR
  } fu_op_t;

  // ARM encoding order, so bit 0 inverts the base relation
  typedef enum logic [3:0] {
    EQ,
    NE,
    CS,
    CC,
    MI,
    PL,
    VS,
    VC,
    HI,
    LS,
    GE,
    LT,
    GT,
    LE,
    AL,
    NV
  } cond_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

endpackage

// File: logic/issue_if.sv
interface issue_if
  import exec_pkg::*;
();

  logic     valid;
  logic     ready;
  fu_op_t   op;
  word_t    val_a;
  word_t    val_b;
  rob_idx_t rob_index;

  // Reservation-station side
  modport source (
    output valid,
    output op,
    output val_a,
    output val_b,
    output rob_index,
    input  ready
  );

  // Functional-unit side
  modport sink (
    input  valid,
    input  op,
    input  val_a,
    input  val_b,
    input  rob_index,
    output ready
  );

endinterface

// File: logic/result_if.sv
interface result_if
  import exec_pkg::*;
();

  logic     valid;
  logic     ready;
  rob_idx_t rob_index;
  word_t    value;
  logic     set_nzcv;
  nzcv_t    nzcv;

  // Producer of a completed micro-op
  modport source (
    output valid,
    output rob_index,
    output value,
    output set_nzcv,
    output nzcv,
    input  ready
  );

  // Consumer, the arbiter or the ROB
  modport sink (
    input  valid,
    input  rob_index,
    input  value,
    input  set_nzcv,
    input  nzcv,
    output ready
  );

endinterface

// File: logic/cond_eval.sv
module cond_eval
  import exec_pkg::*;
(
  input  cond_t cond,
  input  nzcv_t nzcv,
  output logic  holds
);

  logic base;

  always_comb begin
    // Upper three bits select the relation
    case (cond[3:1])
      3'd0: base = nzcv.z;
      3'd1: base = nzcv.c;
      3'd2: base = nzcv.n;
      3'd3: base = nzcv.v;
      3'd4: base = nzcv.c & ~nzcv.z;
      3'd5: base = (nzcv.n == nzcv.v);
      3'd6: base = ~nzcv.z & (nzcv.n == nzcv.v);
      default: base = 1'b1;
    endcase

    // AL and NV both hold, so no inversion for that pair
    if (cond[0] && (cond[3:1] != 3'd7)) begin
      holds = ~base;
    end else begin
      holds = base;
    end
  end

endmodule

// File: logic/alu_unit.sv
module alu_unit
  import exec_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  issue_if.sink issue,
  input  logic  set_nzcv,
  input  cond_t cond,
  input  nzcv_t nzcv_in,
  result_if.source res
);

  word_t       a;
  word_t       b;
  word_t       result;
  word_t       diff;
  logic [64:0] sum_ext;
  logic        cond_holds;
  nzcv_t       flags;
  logic        accept;

  // One-entry output buffer
  logic     out_valid;
  rob_idx_t out_rob_index;
  word_t    out_value;
  logic     out_set_nzcv;
  nzcv_t    out_nzcv;

  assign a = issue.val_a;
  assign b = issue.val_b;

  cond_eval u_cond_eval (
    .cond  (cond),
    .nzcv  (nzcv_in),
    .holds (cond_holds)
  );

  always_comb begin
    sum_ext = {1'b0, a} + {1'b0, b};
    diff    = a - b;
    case (issue.op)
      FU_OP_PLUS:  result = sum_ext[63:0];
      FU_OP_MINUS: result = diff;
      FU_OP_ORN:   result = a | ~b;
      FU_OP_OR:    result = a | b;
      FU_OP_EOR:   result = a ^ b;
      FU_OP_AND:   result = a & b;
      FU_OP_CSNEG: result = cond_holds ? a : -b;
      FU_OP_CSINC: result = cond_holds ? a : b + 64'd1;
      FU_OP_CSINV: result = cond_holds ? a : ~b;
      FU_OP_CSEL:  result = cond_holds ? a : b;
      // No move-wide shift, operands are simply merged
      FU_OP_MOV:   result = a | b;
      default:     result = '0;
    endcase

    flags = nzcv_in;
    if (set_nzcv) begin
      flags.n = result[63];
      flags.z = (result == '0);
      flags.c = 1'b0;
      flags.v = 1'b0;
      if (issue.op == FU_OP_PLUS) begin
        flags.c = sum_ext[64];
        flags.v = (a[63] == b[63]) && (result[63] != a[63]);
      end else if (issue.op == FU_OP_MINUS) begin
        // No borrow means carry set
        flags.c = (a >= b);
        flags.v = (a[63] != b[63]) && (result[63] != a[63]);
      end
    end
  end

  // Buffer empty, or being drained this cycle
  assign issue.ready = ~out_valid | res.ready;
  assign accept      = issue.valid & issue.ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (res.ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_rob_index <= issue.rob_index;
      out_value     <= result;
      out_set_nzcv  <= set_nzcv;
      out_nzcv      <= flags;
    end
  end

  assign res.valid     = out_valid;
  assign res.rob_index = out_rob_index;
  assign res.value     = out_value;
  assign res.set_nzcv  = out_set_nzcv;
  assign res.nzcv      = out_nzcv;

endmodule

// File: logic/data_mem.sv
module data_mem
  import exec_pkg::*;
#(
  parameter int MEM_WORDS = 256
) (
  input  logic  clk,
  input  logic  en,
  input  logic  we,
  input  word_t addr,
  input  word_t wdata,
  output word_t rdata
);

  localparam int IDX_W  = $clog2(MEM_WORDS);
  localparam int BYTE_W = IDX_W + 3;

  logic [7:0] mem [MEM_WORDS*8];

  logic [IDX_W-1:0]  word_idx;
  logic [BYTE_W-1:0] base;

  // Low three address bits dropped, so every access is aligned
  assign word_idx = addr[3 +: IDX_W];
  assign base     = {word_idx, 3'b000};

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        // Little endian, byte 0 at the lowest address
        for (int i = 0; i < 8; i++) begin
          mem[base + BYTE_W'(i)] <= wdata[8*i +: 8];
        end
      end else begin
        for (int i = 0; i < 8; i++) begin
          rdata[8*i +: 8] <= mem[base + BYTE_W'(i)];
        end
      end
    end
  end

endmodule

// File: logic/load_store_unit.sv
module load_store_unit
  import exec_pkg::*;
#(
  parameter int MEM_WORDS = 256
) (
  input  logic  clk,
  input  logic  reset,
  issue_if.sink issue,
  result_if.source res
);

  // Stage 1, memory access
  logic     s1_valid;
  fu_op_t   s1_op;
  word_t    s1_addr;
  word_t    s1_data;
  rob_idx_t s1_rob_index;

  // Stage 2, result hold
  logic     s2_valid;
  logic     s2_is_load;
  word_t    s2_store_data;
  rob_idx_t s2_rob_index;

  logic  s2_free;
  logic  s1_advance;
  logic  accept;
  word_t mem_rdata;

  assign s2_free     = ~s2_valid | res.ready;
  assign s1_advance  = s1_valid & s2_free;
  assign issue.ready = ~s1_valid | s1_advance;
  assign accept      = issue.valid & issue.ready;

  // Access only when stage 1 moves on, so a stalled read stays put
  data_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) u_data_mem (
    .clk   (clk),
    .en    (s1_advance),
    .we    (s1_op == FU_OP_STUR),
    .addr  (s1_addr),
    .wdata (s1_data),
    .rdata (mem_rdata)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (accept) begin
        s1_valid <= 1'b1;
      end else if (s1_advance) begin
        s1_valid <= 1'b0;
      end

      if (s1_advance) begin
        s2_valid <= 1'b1;
      end else if (res.ready) begin
        s2_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      s1_op        <= issue.op;
      s1_addr      <= issue.val_a;
      s1_data      <= issue.val_b;
      s1_rob_index <= issue.rob_index;
    end
    if (s1_advance) begin
      s2_is_load    <= (s1_op == FU_OP_LDUR);
      s2_store_data <= s1_data;
      s2_rob_index  <= s1_rob_index;
    end
  end

  assign res.valid     = s2_valid;
  assign res.rob_index = s2_rob_index;
  assign res.value     = s2_is_load ? mem_rdata : s2_store_data;
  assign res.set_nzcv  = 1'b0;
  assign res.nzcv      = '0;

endmodule

// File: logic/result_arbiter.sv
module result_arbiter (
  input  logic clk,
  input  logic reset,
  result_if.sink   alu_res,
  result_if.sink   ls_res,
  result_if.source rob_res
);

  // Priority pointer, high when load-store goes first on a tie
  logic prio_ls;

  // Grant kept while the ROB stalls, so the payload stays steady
  logic hold_valid;
  logic hold_ls;

  logic grant_ls;
  logic grant_alu;

  always_comb begin
    if (hold_valid) begin
      grant_ls = hold_ls;
    end else begin
      grant_ls = ls_res.valid & (~alu_res.valid | prio_ls);
    end
    grant_alu = alu_res.valid & ~grant_ls;
  end

  assign rob_res.valid     = alu_res.valid | ls_res.valid;
  assign rob_res.rob_index = grant_ls ? ls_res.rob_index : alu_res.rob_index;
  assign rob_res.value     = grant_ls ? ls_res.value : alu_res.value;
  assign rob_res.set_nzcv  = grant_ls ? ls_res.set_nzcv : alu_res.set_nzcv;
  assign rob_res.nzcv      = grant_ls ? ls_res.nzcv : alu_res.nzcv;

  assign alu_res.ready = rob_res.ready & grant_alu;
  assign ls_res.ready  = rob_res.ready & grant_ls;

  always_ff @(posedge clk) begin
    if (reset) begin
      prio_ls    <= 1'b0;
      hold_valid <= 1'b0;
      hold_ls    <= 1'b0;
    end else begin
      hold_valid <= rob_res.valid & ~rob_res.ready;
      hold_ls    <= grant_ls;
      // Served side drops to the back
      if (rob_res.valid && rob_res.ready) begin
        prio_ls <= grant_alu;
      end
    end
  end

endmodule

// File: logic/exec_cluster.sv
module exec_cluster
  import exec_pkg::*;
#(
  parameter int MEM_WORDS = 256
) (
  input  logic     clk,
  input  logic     reset,

  // ALU issue port
  input  logic     alu_valid,
  output logic     alu_ready,
  input  fu_op_t   alu_op,
  input  word_t    alu_val_a,
  input  word_t    alu_val_b,
  input  rob_idx_t alu_rob_index,
  input  logic     alu_set_nzcv,
  input  nzcv_t    alu_nzcv,
  input  cond_t    alu_cond,

  // Load-store issue port
  input  logic     ls_valid,
  output logic     ls_ready,
  input  fu_op_t   ls_op,
  input  word_t    ls_val_a,
  input  word_t    ls_val_b,
  input  rob_idx_t ls_rob_index,

  // Completion toward the ROB
  output logic     rob_valid,
  input  logic     rob_ready,
  output rob_idx_t rob_rob_index,
  output word_t    rob_value,
  output logic     rob_set_nzcv,
  output nzcv_t    rob_nzcv
);

  issue_if  alu_issue ();
  issue_if  ls_issue ();
  result_if alu_res ();
  result_if ls_res ();
  result_if rob_res ();

  assign alu_issue.valid     = alu_valid;
  assign alu_issue.op        = alu_op;
  assign alu_issue.val_a     = alu_val_a;
  assign alu_issue.val_b     = alu_val_b;
  assign alu_issue.rob_index = alu_rob_index;
  assign alu_ready           = alu_issue.ready;

  assign ls_issue.valid     = ls_valid;
  assign ls_issue.op        = ls_op;
  assign ls_issue.val_a     = ls_val_a;
  assign ls_issue.val_b     = ls_val_b;
  assign ls_issue.rob_index = ls_rob_index;
  assign ls_ready           = ls_issue.ready;

  assign rob_valid     = rob_res.valid;
  assign rob_rob_index = rob_res.rob_index;
  assign rob_value     = rob_res.value;
  assign rob_set_nzcv  = rob_res.set_nzcv;
  assign rob_nzcv      = rob_res.nzcv;
  assign rob_res.ready = rob_ready;

  alu_unit u_alu_unit (
    .clk      (clk),
    .reset    (reset),
    .issue    (alu_issue.sink),
    .set_nzcv (alu_set_nzcv),
    .cond     (alu_cond),
    .nzcv_in  (alu_nzcv),
    .res      (alu_res.source)
  );

  load_store_unit #(
    .MEM_WORDS (MEM_WORDS)
  ) u_load_store_unit (
    .clk   (clk),
    .reset (reset),
    .issue (ls_issue.sink),
    .res   (ls_res.source)
  );

  result_arbiter u_result_arbiter (
    .clk     (clk),
    .reset   (reset),
    .alu_res (alu_res.sink),
    .ls_res  (ls_res.sink),
    .rob_res (rob_res.source)
  );

endmodule

// File: test/exec_cluster_tb.sv
module exec_cluster_tb
  import exec_pkg::*;
();

  localparam int MEM_WORDS = 16;
  localparam int N_ALU = 400;
  localparam int N_LS = 200;
  localparam int N_OPS = N_ALU + N_LS;
  localparam int CYCLE_LIMIT = 20 * N_OPS + 200;
  localparam int unsigned SEED = 32'h1e42_ebf7;

  // Expected completion of one outstanding micro-op
  typedef struct packed {
    word_t value;
    nzcv_t nzcv;
    logic  set_nzcv;
    logic  is_ls;
    logic  is_store;
    int    word;
    int    cycle;
  } expect_t;

  logic     clk;
  logic     reset;
  logic     alu_valid;
  logic     alu_ready;
  fu_op_t   alu_op;
  word_t    alu_val_a;
  word_t    alu_val_b;
  rob_idx_t alu_rob_index;
  logic     alu_set_nzcv;
  nzcv_t    alu_nzcv;
  cond_t    alu_cond;
  logic     ls_valid;
  logic     ls_ready;
  fu_op_t   ls_op;
  word_t    ls_val_a;
  word_t    ls_val_b;
  rob_idx_t ls_rob_index;
  logic     rob_valid;
  logic     rob_ready;
  rob_idx_t rob_rob_index;
  word_t    rob_value;
  logic     rob_set_nzcv;
  nzcv_t    rob_nzcv;

  // Owned by the stimulus process
  int      alloc_gen [32];
  int      store_issued [MEM_WORDS];
  bit      written [MEM_WORDS];
  word_t   ref_mem [MEM_WORDS];
  expect_t stage_alu;
  expect_t stage_ls;
  int      alu_sent;
  int      ls_sent;

  // Owned by the completion monitor
  int       done_gen [32];
  int       store_done [MEM_WORDS];
  expect_t  expected [rob_idx_t];
  rob_idx_t alu_order [$];
  rob_idx_t ls_order [$];
  int       alu_issued;
  int       ls_issued;
  int       alu_completed;
  int       ls_completed;
  int       check_errors;
  int       protocol_errors;
  int       cycles;

  exec_cluster #(
    .MEM_WORDS (MEM_WORDS)
  ) u_exec_cluster (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // ARM condition table
  function automatic logic cond_passes(input cond_t c, input nzcv_t f);
    case (c)
      EQ: return f.z;
      NE: return !f.z;
      CS: return f.c;
      CC: return !f.c;
      MI: return f.n;
      PL: return !f.n;
      VS: return f.v;
      VC: return !f.v;
      HI: return f.c && !f.z;
      LS: return !(f.c && !f.z);
      GE: return f.n == f.v;
      LT: return f.n != f.v;
      GT: return !f.z && (f.n == f.v);
      LE: return !(!f.z && (f.n == f.v));
      default: return 1'b1;
    endcase
  endfunction

  function automatic void model_alu(input fu_op_t op, input word_t a, input word_t b,
                                    input logic set, input nzcv_t f_in, input cond_t c,
                                    output word_t r, output nzcv_t f);
    logic [64:0] carry_sum;
    logic [64:0] sx_sum;
    logic [64:0] sx_diff;
    logic        sel;
    sel       = cond_passes(c, f_in);
    carry_sum = {1'b0, a} + {1'b0, b};
    sx_sum    = {a[63], a} + {b[63], b};
    sx_diff   = {a[63], a} - {b[63], b};
    case (op)
      FU_OP_PLUS:  r = carry_sum[63:0];
      FU_OP_MINUS: r = sx_diff[63:0];
      FU_OP_ORN:   r = a | ~b;
      FU_OP_OR:    r = a | b;
      FU_OP_EOR:   r = a ^ b;
      FU_OP_AND:   r = a & b;
      FU_OP_CSNEG: r = sel ? a : (~b + 64'd1);
      FU_OP_CSINC: r = sel ? a : (b + 64'd1);
      FU_OP_CSINV: r = sel ? a : ~b;
      FU_OP_CSEL:  r = sel ? a : b;
      // MOV merges both operands
      default:     r = a | b;
    endcase
    f = f_in;
    if (set) begin
      f.n = r[63];
      f.z = (r == 64'd0);
      f.c = 1'b0;
      f.v = 1'b0;
      if (op == FU_OP_PLUS) begin
        f.c = carry_sum[64];
        f.v = sx_sum[64] != sx_sum[63];
      end else if (op == FU_OP_MINUS) begin
        f.c = (a >= b);
        f.v = sx_diff[64] != sx_diff[63];
      end
    end
  endfunction

  // Frequent corner values reach carry and overflow
  function automatic word_t pick_operand();
    case ($urandom_range(0, 7))
      0: return 64'd0;
      1: return '1;
      2: return 64'h8000_0000_0000_0000;
      3: return 64'h7fff_ffff_ffff_ffff;
      default: return {$urandom, $urandom};
    endcase
  endfunction

  function automatic int find_free_index();
    int start;
    int idx;
    start = int'($urandom_range(0, 31));
    for (int k = 0; k < 32; k++) begin
      idx = (start + k) % 32;
      if (alloc_gen[idx] == done_gen[idx]) begin
        return idx;
      end
    end
    return -1;
  endfunction

  function automatic int position_of(input rob_idx_t q[$], input rob_idx_t idx);
    for (int k = 0; k < q.size(); k++) begin
      if (q[k] == idx) begin
        return k;
      end
    end
    return -1;
  endfunction

  initial begin
    while (alu_completed < N_ALU || ls_completed < N_LS) begin
      @(negedge clk);
    end
    // Idle tail catches stray completions
    repeat (10) @(negedge clk);
    $display("Done %0d ALU, %0d load-store; %0d check errors, %0d protocol errors, %0d pending",
             alu_completed, ls_completed, check_errors, protocol_errors, expected.num());
    if (check_errors == 0 && protocol_errors == 0 && expected.num() == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Stimulus on the falling edge
  initial begin
    int    idx;
    int    w;
    int    drive_cycle;
    word_t addr;
    void'($urandom(SEED));
    reset = 1'b1;
    alu_valid = 1'b0;
    alu_op = FU_OP_PLUS;
    alu_val_a = '0;
    alu_val_b = '0;
    alu_rob_index = '0;
    alu_set_nzcv = 1'b0;
    alu_nzcv = '0;
    alu_cond = AL;
    ls_valid = 1'b0;
    ls_op = FU_OP_LDUR;
    ls_val_a = '0;
    ls_val_b = '0;
    ls_rob_index = '0;
    rob_ready = 1'b0;
    drive_cycle = 0;
    forever begin
      @(negedge clk);
      drive_cycle++;
      // Reset covers the first ten rising edges
      if (drive_cycle == 10) begin
        reset = 1'b0;
      end
      // Stretches of random stalls alternate with a free bus
      if (((drive_cycle / 64) % 2) == 1) begin
        rob_ready = 1'b1;
      end else begin
        rob_ready = ($urandom_range(0, 99) < 60);
      end
      if (!reset && !(alu_valid && alu_issued < alu_sent)) begin
        alu_valid = 1'b0;
        idx = (alu_sent < N_ALU && $urandom_range(0, 3) != 0) ? find_free_index() : -1;
        if (idx >= 0) begin
          alloc_gen[idx]++;
          alu_op = fu_op_t'(4'($urandom_range(0, 10)));
          alu_val_a = pick_operand();
          alu_val_b = pick_operand();
          alu_rob_index = rob_idx_t'(idx);
          alu_set_nzcv = 1'($urandom_range(0, 1));
          alu_nzcv = nzcv_t'(4'($urandom_range(0, 15)));
          alu_cond = cond_t'(4'($urandom_range(0, 15)));
          stage_alu = '0;
          stage_alu.set_nzcv = alu_set_nzcv;
          model_alu(alu_op, alu_val_a, alu_val_b, alu_set_nzcv, alu_nzcv, alu_cond,
                    stage_alu.value, stage_alu.nzcv);
          alu_valid = 1'b1;
          alu_sent++;
        end
      end
      if (!reset && !(ls_valid && ls_issued < ls_sent)) begin
        ls_valid = 1'b0;
        idx = (ls_sent < N_LS && $urandom_range(0, 3) != 0) ? find_free_index() : -1;
        if (idx >= 0) begin
          alloc_gen[idx]++;
          addr = {$urandom, $urandom};
          w = int'((addr >> 3) % MEM_WORDS);
          ls_val_a = addr;
          ls_val_b = pick_operand();
          ls_rob_index = rob_idx_t'(idx);
          stage_ls = '0;
          stage_ls.is_ls = 1'b1;
          stage_ls.word = w;
          // Load only a written word with no store still in flight
          if (written[w] && store_issued[w] == store_done[w] && $urandom_range(0, 1) == 1) begin
            ls_op = FU_OP_LDUR;
            stage_ls.value = ref_mem[w];
          end else begin
            ls_op = FU_OP_STUR;
            ref_mem[w] = ls_val_b;
            written[w] = 1'b1;
            store_issued[w]++;
            stage_ls.value = ls_val_b;
            stage_ls.is_store = 1'b1;
          end
          ls_valid = 1'b1;
          ls_sent++;
        end
      end
    end
  end

  always @(posedge clk) begin : monitor
    bit       reset_q;
    bit       prev_fire;
    bit       prev_ls;
    bit       alu_holds;
    bit       ls_holds;
    bit       from_ls;
    int       pos;
    rob_idx_t idx;
    expect_t  exp;
    if (reset) begin
      reset_q = 1'b1;
      prev_fire = 1'b0;
    end else begin
      if (reset_q) begin
        assert (!rob_valid && alu_ready && ls_ready) else begin
          check_errors++;
          $display("Error %0t: after reset rob_valid=%b alu_ready=%b ls_ready=%b",
                   $time, rob_valid, alu_ready, ls_ready);
        end
      end
      reset_q = 1'b0;
      // A unit holds a result once its oldest op has passed its latency
      alu_holds = 1'b0;
      ls_holds = 1'b0;
      if (alu_order.size() > 0) begin
        alu_holds = expected[alu_order[0]].cycle <= cycles - 1;
      end
      if (ls_order.size() > 0) begin
        ls_holds = expected[ls_order[0]].cycle <= cycles - 2;
      end
      from_ls = 1'b0;
      if (rob_valid && rob_ready) begin
        idx = rob_rob_index;
        assert (expected.exists(idx)) else begin
          check_errors++;
          $display("Error %0t: completion for rob index %0d with nothing outstanding", $time, idx);
        end
        if (expected.exists(idx)) begin
          exp = expected[idx];
          from_ls = exp.is_ls;
          assert (rob_value === exp.value) else begin
            check_errors++;
            $display("Error %0t: rob index %0d value %h, expected %h",
                     $time, idx, rob_value, exp.value);
          end
          assert (rob_set_nzcv === exp.set_nzcv && rob_nzcv === exp.nzcv) else begin
            check_errors++;
            $display("Error %0t: rob index %0d flags %b/%b, expected %b/%b",
                     $time, idx, rob_set_nzcv, rob_nzcv, exp.set_nzcv, exp.nzcv);
          end
          pos = from_ls ? position_of(ls_order, idx) : position_of(alu_order, idx);
          assert (pos == 0) else begin
            check_errors++;
            $display("Error %0t: rob index %0d completed out of unit order", $time, idx);
          end
          if (from_ls) begin
            ls_order.delete(pos);
            ls_completed++;
          end else begin
            alu_order.delete(pos);
            alu_completed++;
          end
          if (exp.is_store) begin
            store_done[exp.word]++;
          end
          done_gen[idx]++;
          expected.delete(idx);
        end
        if (prev_fire && alu_holds && ls_holds) begin
          assert (from_ls != prev_ls) else begin
            check_errors++;
            $display("Error %0t: two %s completions in a row while both units waited",
                     $time, from_ls ? "load-store" : "ALU");
          end
        end
        prev_ls = from_ls;
      end
      prev_fire = rob_valid && rob_ready;
      if (alu_valid && alu_ready) begin
        exp = stage_alu;
        exp.cycle = cycles;
        expected[alu_rob_index] = exp;
        alu_order.push_back(alu_rob_index);
        alu_issued++;
      end
      if (ls_valid && ls_ready) begin
        exp = stage_ls;
        exp.cycle = cycles;
        expected[ls_rob_index] = exp;
        ls_order.push_back(ls_rob_index);
        ls_issued++;
      end
    end
  end

  // Stalled completion must keep its payload
  payload_hold: assert property (@(posedge clk) disable iff (reset)
    (rob_valid && !rob_ready) |=> (rob_valid && $stable(rob_rob_index) && $stable(rob_value)
      && $stable(rob_set_nzcv) && $stable(rob_nzcv)))
  else begin
    protocol_errors++;
    $display("Error %0t: rob payload changed while stalled", $time);
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run stopped after %0d cycles with %0d of %0d micro-ops completed",
               cycles, alu_completed + ls_completed, N_OPS);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

endmodule

// File: sim.f
logic/exec_pkg.sv
logic/issue_if.sv
logic/result_if.sv
logic/cond_eval.sv
logic/alu_unit.sv
logic/data_mem.sv
logic/load_store_unit.sv
logic/result_arbiter.sv
logic/exec_cluster.sv
test/exec_cluster_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module exec_cluster_tb -f sim.f

output=$(./obj_dir/Vexec_cluster_tb)
echo "$output"

if grep -qF -- '*** TEST PASSED ***' <<< "$output"; then
  exit 0
fi
echo "Simulation did not report a pass"
exit 1
